//--- all.f
+incdir+tb
hw/fifo_pkg.sv
hw/frame_pkg.sv
hw/gray_ptr_sync.sv
hw/async_fifo.sv
hw/sum_check.sv
hw/frame_parser.sv
hw/cdc_frame_bridge.sv
tb/tb_cdc_frame_bridge.sv

//--- hw/async_fifo.sv
module async_fifo #(
    parameter int ADDR_W      = 2,
    parameter int SYNC_STAGES = 2
) (
    // Write side
    input  logic             wclk,
    input  logic             rrst,
    input  logic             wr_en_i,
    input  frame_pkg::word_t wr_data_i,
    output logic             full_o,

    // Read side
    input  logic             rclk,
    input  logic             pop_i,
    output frame_pkg::word_t rd_data_o,
    output logic             empty_o
);
    import fifo_pkg::*;
    import frame_pkg::*;

    localparam int   DEPTH    = 2 ** ADDR_W;
    localparam ptr_t PTR_MASK = ptr_mask(ADDR_W + 1);

    word_t mem [DEPTH];

    ptr_t wptr_q;
    ptr_t wgray_q;
    ptr_t wptr_next;
    ptr_t rptr_q;
    ptr_t rgray_q;
    ptr_t rptr_next;
    ptr_t wptr_sync;     // Write pointer seen from rclk
    ptr_t rptr_sync;     // Read pointer seen from wclk
    logic wr_ok;
    logic rd_ok;

    assign wr_ok = wr_en_i && !full_o;   // Writes into a full FIFO are dropped
    assign rd_ok = pop_i && !empty_o;

    assign wptr_next = (wptr_q + ptr_t'(wr_ok)) & PTR_MASK;
    assign rptr_next = (rptr_q + ptr_t'(rd_ok)) & PTR_MASK;

    always_ff @(posedge wclk) begin
        if (rrst) begin
            wptr_q  <= '0;
            wgray_q <= '0;
        end else begin
            wptr_q  <= wptr_next;
            wgray_q <= gray_enc(wptr_next);   // Registered so no glitch crosses over
        end
    end

    always_ff @(posedge wclk) begin
        if (wr_ok) begin
            mem[wptr_q[ADDR_W-1:0]] <= wr_data_i;
        end
    end

    always_ff @(posedge rclk) begin
        if (rrst) begin
            rptr_q  <= '0;
            rgray_q <= '0;
        end else begin
            rptr_q  <= rptr_next;
            rgray_q <= gray_enc(rptr_next);
        end
    end

    // Head word, first-word fall-through
    assign rd_data_o = mem[rptr_q[ADDR_W-1:0]];

    gray_ptr_sync #(
        .ADDR_W      (ADDR_W),
        .SYNC_STAGES (SYNC_STAGES)
    ) u_wptr_sync (
        .clk_i  (rclk),
        .rst_i  (rrst),
        .gray_i (wgray_q),
        .bin_o  (wptr_sync)
    );

    gray_ptr_sync #(
        .ADDR_W      (ADDR_W),
        .SYNC_STAGES (SYNC_STAGES)
    ) u_rptr_sync (
        .clk_i  (wclk),
        .rst_i  (rrst),
        .gray_i (rgray_q),
        .bin_o  (rptr_sync)
    );

    assign empty_o = (wptr_sync == rptr_q);

    // Same slot, one lap apart
    assign full_o = (wptr_q[ADDR_W-1:0] == rptr_sync[ADDR_W-1:0])
                 && (wptr_q[ADDR_W] != rptr_sync[ADDR_W]);

endmodule

//--- hw/cdc_frame_bridge.sv
module cdc_frame_bridge #(
    parameter int ADDR_W      = 3,
    parameter int SYNC_STAGES = 3
) (
    input  logic                  wclk,
    input  logic                  rclk,
    input  logic                  rrst,

    // Producer side, wclk
    input  logic                  wr_en_i,
    input  frame_pkg::word_t      wr_data_i,
    output logic                  full_o,

    // Consumer side, rclk
    input  logic                  pause_i,
    output frame_pkg::frame_out_t out_o,
    output logic                  out_valid_o,
    output logic                  frame_ok_o,
    output logic                  frame_err_o,
    output logic                  hdr_err_o
);
    import frame_pkg::*;

    word_t head_word;
    logic  fifo_empty;
    logic  pop;
    logic  sum_clr;
    logic  sum_add;
    logic  sum_cmp;
    logic  sum_match;

    async_fifo #(
        .ADDR_W      (ADDR_W),
        .SYNC_STAGES (SYNC_STAGES)
    ) u_fifo (
        .wclk      (wclk),
        .rrst      (rrst),
        .wr_en_i   (wr_en_i),
        .wr_data_i (wr_data_i),
        .full_o    (full_o),
        .rclk      (rclk),
        .pop_i     (pop),
        .rd_data_o (head_word),
        .empty_o   (fifo_empty)
    );

    frame_parser u_parser (
        .rclk        (rclk),
        .rrst        (rrst),
        .empty_i     (fifo_empty),
        .word_i      (head_word),
        .pause_i     (pause_i),
        .pop_o       (pop),
        .clr_o       (sum_clr),
        .add_o       (sum_add),
        .cmp_o       (sum_cmp),
        .match_i     (sum_match),
        .out_o       (out_o),
        .out_valid_o (out_valid_o),
        .frame_ok_o  (frame_ok_o),
        .frame_err_o (frame_err_o),
        .hdr_err_o   (hdr_err_o)
    );

    // Runs in the read domain
    sum_check u_sum (
        .wclk     (rclk),
        .rrst     (rrst),
        .clr_i    (sum_clr),
        .add_i    (sum_add),
        .cmp_i    (sum_cmp),
        .data_i   (head_word),
        .expect_i (head_word),
        .match_o  (sum_match)
    );

endmodule

//--- hw/fifo_pkg.sv
package fifo_pkg;

    // Widest pointer the helpers handle
    localparam int unsigned PTR_W = 8;

    typedef logic [PTR_W-1:0] ptr_t;

    // Keeps the low width bits of a pointer
    function automatic ptr_t ptr_mask(input int unsigned width);
        ptr_t m;
        m = '0;
        for (int i = 0; i < PTR_W; i++) begin
            if (i < width) begin
                m[i] = 1'b1;
            end
        end
        return m;
    endfunction

    function automatic ptr_t gray_enc(input ptr_t bin);
        return bin ^ (bin >> 1);
    endfunction

    // Zeros above the used width decode to zeros
    function automatic ptr_t gray_dec(input ptr_t gray);
        ptr_t bin;
        bin[PTR_W-1] = gray[PTR_W-1];
        for (int i = PTR_W - 2; i >= 0; i--) begin
            bin[i] = bin[i+1] ^ gray[i];
        end
        return bin;
    endfunction

endpackage

//--- hw/frame_parser.sv
module frame_parser (
    input  logic                  rclk,
    input  logic                  rrst,

    // FIFO head
    input  logic                  empty_i,
    input  frame_pkg::word_t      word_i,
    input  logic                  pause_i,
    output logic                  pop_o,

    // Checksum unit
    output logic                  clr_o,
    output logic                  add_o,
    output logic                  cmp_o,
    input  logic                  match_i,

    // Frame outputs
    output frame_pkg::frame_out_t out_o,
    output logic                  out_valid_o,
    output logic                  frame_ok_o,
    output logic                  frame_err_o,
    output logic                  hdr_err_o
);
    import frame_pkg::*;

    typedef enum logic [1:0] {
        S_HEADER,
        S_PAYLOAD,
        S_CHECK
    } state_t;

    state_t      state_q;
    chan_t       chan_q;
    len_t        remain_q;    // Payload words still to come
    frame_word_u word;
    logic        hdr_ok;
    logic        last_word;

    assign word = word_i;

    assign pop_o     = !empty_i && !pause_i;
    assign hdr_ok    = (word.hdr.magic == HDR_MAGIC);
    assign last_word = (remain_q == len_t'(1));

    assign clr_o = pop_o && (state_q == S_HEADER) && hdr_ok;
    assign add_o = pop_o && (state_q == S_PAYLOAD);
    assign cmp_o = pop_o && (state_q == S_CHECK);

    always_ff @(posedge rclk) begin
        if (rrst) begin
            state_q     <= S_HEADER;
            chan_q      <= '0;
            remain_q    <= '0;
            out_valid_o <= 1'b0;
            frame_ok_o  <= 1'b0;
            frame_err_o <= 1'b0;
            hdr_err_o   <= 1'b0;
        end else begin
            out_valid_o <= 1'b0;
            frame_ok_o  <= 1'b0;
            frame_err_o <= 1'b0;
            hdr_err_o   <= 1'b0;
            if (pop_o) begin
                case (state_q)
                    S_HEADER: begin
                        if (hdr_ok) begin
                            chan_q   <= word.hdr.channel;
                            remain_q <= word.hdr.length;
                            // Empty frame skips straight to its checksum
                            state_q  <= (word.hdr.length == '0) ? S_CHECK : S_PAYLOAD;
                        end else begin
                            hdr_err_o <= 1'b1;   // Stray word, dropped
                        end
                    end
                    S_PAYLOAD: begin
                        out_valid_o <= 1'b1;
                        remain_q    <= remain_q - len_t'(1);
                        if (last_word) begin
                            state_q <= S_CHECK;
                        end
                    end
                    S_CHECK: begin
                        frame_ok_o  <= match_i;
                        frame_err_o <= !match_i;
                        state_q     <= S_HEADER;
                    end
                    default: begin
                        state_q <= S_HEADER;
                    end
                endcase
            end
        end
    end

    always_ff @(posedge rclk) begin
        if (add_o) begin
            out_o.data    <= word.raw;
            out_o.channel <= chan_q;
            out_o.last    <= last_word;
        end
    end

endmodule

//--- hw/frame_pkg.sv
package frame_pkg;

    typedef logic [15:0] word_t;
    typedef logic [3:0]  chan_t;
    typedef logic [7:0]  len_t;

    // Top nibble of every header word
    localparam logic [3:0] HDR_MAGIC = 4'hA;

    typedef struct packed {
        logic [3:0] magic;
        chan_t      channel;
        len_t       length;    // Payload words that follow
    } frame_hdr_t;

    // Same FIFO word seen as header or as payload/checksum
    typedef union packed {
        frame_hdr_t hdr;
        word_t      raw;
    } frame_word_u;

    typedef struct packed {
        word_t data;
        chan_t channel;
        logic  last;           // Final payload word of the frame
    } frame_out_t;

endpackage

//--- hw/gray_ptr_sync.sv
module gray_ptr_sync #(
    parameter int ADDR_W      = 2,
    parameter int SYNC_STAGES = 2
) (
    input  logic            clk_i,
    input  logic            rst_i,
    input  fifo_pkg::ptr_t  gray_i,
    output fifo_pkg::ptr_t  bin_o
);
    import fifo_pkg::*;

    localparam ptr_t PTR_MASK = ptr_mask(ADDR_W + 1);

    ptr_t sync_q [SYNC_STAGES];

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            sync_q <= '{default: '0};
        end else begin
            sync_q[0] <= gray_i & PTR_MASK;   // First stage may go metastable
            for (int i = 1; i < SYNC_STAGES; i++) begin
                sync_q[i] <= sync_q[i-1];
            end
        end
    end

    assign bin_o = gray_dec(sync_q[SYNC_STAGES-1]);

endmodule

//--- hw/sum_check.sv
module sum_check (
    input  logic             wclk,
    input  logic             rrst,
    input  logic             clr_i,
    input  logic             add_i,
    input  logic             cmp_i,
    input  frame_pkg::word_t data_i,
    input  frame_pkg::word_t expect_i,
    output logic             match_o
);
    import frame_pkg::*;

    word_t acc_q;

    // Wraps at 2^16
    always_ff @(posedge wclk) begin
        if (rrst) begin
            acc_q <= '0;
        end else if (clr_i) begin
            acc_q <= '0;
        end else if (add_i) begin
            acc_q <= acc_q + data_i;
        end
    end

    // Only meaningful while the checksum word is at the head
    assign match_o = cmp_i && (acc_q == expect_i);

endmodule

//--- tb/tb_frames.svh
`ifndef TB_FRAMES_SVH
`define TB_FRAMES_SVH

// Expected pulse pattern {frame_ok_o, frame_err_o, hdr_err_o}
localparam logic [2:0] ST_OK  = 3'b100;
localparam logic [2:0] ST_ERR = 3'b010;
localparam logic [2:0] ST_HDR = 3'b001;

typedef struct packed {
    logic        stray;     // Lone word without the magic nibble
    logic [3:0]  channel;
    logic [7:0]  length;
    logic [15:0] seed;      // Ramp start, zero gives random payload
    logic        bad_sum;   // Checksum word gets corrupted
    logic        pause;     // Popping held off while this frame goes in
    logic [2:0]  status;
} frame_row_t;

localparam int NUM_ROWS = 12;

// For a stray row the seed column is the raw word itself
// stray, channel, length, seed, bad_sum, pause, expected status
localparam frame_row_t FRAME_TABLE [NUM_ROWS] = '{
    '{1'b0, 4'h1, 8'd4,  16'h0000, 1'b0, 1'b0, ST_OK},
    '{1'b0, 4'h2, 8'd0,  16'h0000, 1'b0, 1'b0, ST_OK},
    '{1'b0, 4'h3, 8'd1,  16'h1000, 1'b0, 1'b0, ST_OK},
    '{1'b0, 4'h5, 8'd6,  16'h0000, 1'b1, 1'b0, ST_ERR},
    '{1'b1, 4'h0, 8'd0,  16'h5123, 1'b0, 1'b0, ST_HDR},
    '{1'b0, 4'h6, 8'd3,  16'h0000, 1'b0, 1'b0, ST_OK},
    '{1'b0, 4'h7, 8'd20, 16'h0000, 1'b0, 1'b1, ST_OK},
    '{1'b0, 4'hf, 8'd12, 16'hfff8, 1'b0, 1'b0, ST_OK},   // Sum wraps past 2^16
    '{1'b1, 4'h0, 8'd0,  16'hffff, 1'b0, 1'b0, ST_HDR},
    '{1'b0, 4'h0, 8'd2,  16'h0000, 1'b0, 1'b0, ST_OK},
    '{1'b0, 4'h9, 8'd5,  16'h0000, 1'b1, 1'b0, ST_ERR},
    '{1'b0, 4'h4, 8'd0,  16'h0000, 1'b1, 1'b0, ST_ERR}
};

`endif

//--- tb/tb_cdc_frame_bridge.sv
module tb_cdc_frame_bridge;
    timeunit 1ns;
    timeprecision 1ps;

    import frame_pkg::*;

    `include "tb_frames.svh"

    logic       wclk;
    logic       rclk;
    logic       rrst;
    logic       wr_en_i;
    word_t      wr_data_i;
    logic       full_o;
    logic       pause_i;
    frame_out_t out_o;
    logic       out_valid_o;
    logic       frame_ok_o;
    logic       frame_err_o;
    logic       hdr_err_o;

    frame_out_t exp_words [$];
    logic [2:0] exp_status [$];
    logic       mon_on;
    logic       saw_full;
    int         cycle_count;
    int         cycle_limit;
    event       pause_start;

    cdc_frame_bridge dut (
        .wclk        (wclk),
        .rclk        (rclk),
        .rrst        (rrst),
        .wr_en_i     (wr_en_i),
        .wr_data_i   (wr_data_i),
        .full_o      (full_o),
        .pause_i     (pause_i),
        .out_o       (out_o),
        .out_valid_o (out_valid_o),
        .frame_ok_o  (frame_ok_o),
        .frame_err_o (frame_err_o),
        .hdr_err_o   (hdr_err_o)
    );

    initial begin
        wclk = 1'b0;
        forever #10 wclk = ~wclk;
    end

    // Offset keeps rclk edges off the wclk grid
    initial begin
        rclk = 1'b0;
        #1.5;
        forever begin
            rclk = ~rclk;
            #17;
        end
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [31:0] got,
                         input logic [31:0] expected);
        if (got !== expected) begin
            abort_run($sformatf("FAILED %s: got 0x%0h, expected 0x%0h", name, got, expected));
        end
    endtask

    function automatic int count_words();
        int n;
        n = 0;
        for (int r = 0; r < NUM_ROWS; r++) begin
            n += FRAME_TABLE[r].stray ? 1 : int'(FRAME_TABLE[r].length) + 2;
        end
        return n;
    endfunction

    // Holds the word back while full_o is up
    task automatic write_word(input word_t w);
        @(negedge wclk);
        while (full_o) begin
            saw_full = 1'b1;
            wr_en_i  = 1'b0;
            @(negedge wclk);
        end
        wr_en_i   = 1'b1;
        wr_data_i = w;
    endtask

    task automatic send_row(input frame_row_t row);
        word_t       payload [$];
        logic [31:0] rnd;
        word_t       w;
        word_t       sum;
        frame_hdr_t  hdr;
        frame_out_t  e;
        sum = '0;
        exp_status.push_back(row.status);
        if (row.stray) begin
            write_word(row.seed);
        end else begin
            for (int i = 0; i < int'(row.length); i++) begin
                rnd = $urandom();
                w   = (row.seed != '0) ? word_t'(row.seed + i) : rnd[15:0];
                sum = sum + w;
                payload.push_back(w);
                e.data    = w;
                e.channel = row.channel;
                e.last    = (i == int'(row.length) - 1);
                exp_words.push_back(e);
            end
            hdr.magic   = HDR_MAGIC;
            hdr.channel = row.channel;
            hdr.length  = row.length;
            write_word(hdr);
            foreach (payload[i]) begin
                write_word(payload[i]);
            end
            write_word(row.bad_sum ? (sum ^ 16'h8001) : sum);
        end
    endtask

    initial begin
        forever begin
            @(pause_start);
            @(negedge rclk);
            pause_i  = 1'b1;
            saw_full = 1'b0;
            repeat (40) @(negedge rclk);
            pause_i = 1'b0;
            if (!saw_full) begin
                abort_run("full_o never rose while popping was paused");
            end
        end
    end

    // Run limit in rclk cycles
    initial begin
        cycle_count = 0;
        cycle_limit = 4 * count_words() + 200;
        forever begin
            @(negedge rclk);
            cycle_count++;
            if (cycle_count >= cycle_limit) begin
                abort_run($sformatf("Timeout: frames did not drain within %0d rclk cycles",
                                    cycle_limit));
            end
        end
    end

    always @(negedge rclk) begin
        frame_out_t e;
        if (mon_on) begin
            if (out_valid_o) begin
                if (exp_words.size() == 0) begin
                    abort_run("A payload word came out when none was expected");
                end else begin
                    e = exp_words.pop_front();
                    check("out_o.data", out_o.data, e.data);
                    check("out_o.channel", out_o.channel, e.channel);
                    check("out_o.last", out_o.last, e.last);
                end
            end
            if (frame_ok_o || frame_err_o || hdr_err_o) begin
                if (exp_status.size() == 0) begin
                    abort_run("A status pulse came out when no frame was pending");
                end else begin
                    check("{frame_ok_o,frame_err_o,hdr_err_o}",
                          {frame_ok_o, frame_err_o, hdr_err_o}, exp_status.pop_front());
                end
            end
        end
    end

    initial begin
        void'($urandom(32'hc4fe));
        rrst        = 1'b1;
        wr_en_i     = 1'b0;
        wr_data_i   = '0;
        pause_i     = 1'b0;
        mon_on      = 1'b0;
        saw_full    = 1'b0;

        repeat (8) @(posedge rclk);
        @(negedge rclk);
        rrst = 1'b0;

        @(negedge rclk);
        check("full_o", full_o, 1'b0);
        check("out_valid_o", out_valid_o, 1'b0);
        check("frame_ok_o", frame_ok_o, 1'b0);
        check("frame_err_o", frame_err_o, 1'b0);
        check("hdr_err_o", hdr_err_o, 1'b0);
        mon_on = 1'b1;

        for (int r = 0; r < NUM_ROWS; r++) begin
            if (FRAME_TABLE[r].pause) begin
                -> pause_start;
            end
            send_row(FRAME_TABLE[r]);
        end
        @(negedge wclk);
        wr_en_i = 1'b0;

        while (exp_words.size() != 0 || exp_status.size() != 0) begin
            @(negedge rclk);
        end
        repeat (10) @(negedge rclk);   // Catch any late stray pulse
        $display("TEST PASSED");
        $finish;
    end

endmodule
